//--- Makefile
# Verilator build and run for the fixed-point multiplier

TOP = fixed_mul_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f fixed_mul.f --top-module $(TOP)

# The log decides the result
run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f fixed_mul.f --top-module fixed_mul_top

clean:
	rm -rf obj_dir $(LOG)

//--- fixed_mul.f
+incdir+logic
logic/mul_pkg.sv
logic/cla_adder.sv
logic/radix4_partial_product.sv
logic/mul_datapath.sv
logic/mul_control.sv
logic/fixed_mul_top.sv
test/fixed_mul_tb.sv

//--- logic/cla_adder.sv
// Carry lookahead adder
`timescale 1ns/100ps
`include "mul_consts.svh"

module cla_adder #(
    parameter int width = 32
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    output logic [width:0]   sum
);
    localparam int group     = `MUL_CLA_GROUP;
    localparam int n_groups  = width / group;
    localparam int tail_base = n_groups * group;

    logic [width-1:0] gen;
    logic [width-1:0] prop;
    logic [width:0]   carry;

    assign gen      = a & b;
    assign prop     = a ^ b;
    assign carry[0] = 1'b0;

    for (genvar gi = 0; gi < n_groups; gi++) begin : group_g
        localparam int base = gi * group;

        logic [group-1:0] g_grp;
        logic [group-1:0] p_grp;
        logic [group-1:0] c_out;
        logic             c_in;

        assign g_grp = gen[base +: group];
        assign p_grp = prop[base +: group];
        assign c_in  = carry[base];

        // Each carry is a flat sum of products of the group terms
        always_comb begin
            logic run;
            for (int j = 0; j < group; j++) begin
                run      = 1'b1;
                c_out[j] = 1'b0;
                for (int k = j; k >= 0; k--) begin
                    c_out[j] = c_out[j] | (run & g_grp[k]);
                    run      = run & p_grp[k];
                end
                c_out[j] = c_out[j] | (run & c_in);
            end
        end

        // Group carry out feeds the next group
        assign carry[base+1 +: group] = c_out;
    end

    // Ripple tail for the leftover bits
    for (genvar ti = tail_base; ti < width; ti++) begin : tail_g
        assign carry[ti+1] = gen[ti] | (prop[ti] & carry[ti]);
    end

    assign sum = {carry[width], prop ^ carry[width-1:0]};

endmodule

//--- logic/fixed_mul_top.sv
// Fixed-point multiplier top
`timescale 1ns/100ps

module fixed_mul_top import mul_pkg::*; (
    input  logic     ctl_clk,
    input  logic     reset,
    input  logic     trigger,
    input  mul_req_t req,
    output logic     ready,
    output logic     done,
    output word_t    y
);
    mul_ctrl_t ctrl;

    mul_control control_i (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .ctrl    (ctrl)
    );

    mul_datapath datapath_i (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .req     (req),
        .ctrl    (ctrl),
        .y       (y)
    );

endmodule

//--- logic/mul_consts.svh
// Multiplier constants
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// Operand and result width
`define MUL_WIDTH 32

// Fixed-point fraction bits
`define MUL_FRAC_BITS 8

// Radix-4 digits retired per step
`define MUL_DIGITS_PER_STEP 4

`define MUL_BITS_PER_STEP (2 * `MUL_DIGITS_PER_STEP)

`define MUL_STEPS (`MUL_WIDTH / `MUL_BITS_PER_STEP)

// Lookahead group size
`define MUL_CLA_GROUP 4

`endif

//--- logic/mul_control.sv
// Multiplier control FSM
`timescale 1ns/100ps
`include "mul_consts.svh"

module mul_control import mul_pkg::*; (
    input  logic      ctl_clk,
    input  logic      reset,
    input  logic      trigger,
    output logic      ready,
    output logic      done,
    output mul_ctrl_t ctrl
);
    localparam int                step_w    = $clog2(`MUL_STEPS);
    localparam logic [step_w-1:0] last_step = step_w'(`MUL_STEPS - 1);

    mul_state_t        state;
    logic [step_w-1:0] step;

    assign ready = (state == st_idle);

    // Strobes for the datapath
    always_comb begin
        ctrl.load       = (state == st_idle) && trigger;
        ctrl.accumulate = (state == st_calc);
        ctrl.capture    = (state == st_finish);
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (trigger) begin
                        state <= st_calc;
                        step  <= '0;
                    end
                end
                st_calc: begin
                    step <= step + 1'b1;
                    if (step == last_step) begin
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // One cycle pulse, same edge as the y capture
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            done <= 1'b0;
        end else begin
            done <= (state == st_finish);
        end
    end

endmodule

//--- logic/mul_datapath.sv
// Multiplier datapath
`timescale 1ns/100ps
`include "mul_consts.svh"

module mul_datapath import mul_pkg::*; (
    input  logic      ctl_clk,
    input  logic      reset,
    input  mul_req_t  req,
    input  mul_ctrl_t ctrl,
    output word_t     y
);
    localparam int w    = `MUL_WIDTH;
    localparam int step = `MUL_BITS_PER_STEP;
    localparam int pp_w = w + step;

    word_t    a_reg;
    word_t    b_reg;
    product_t acc;

    logic [pp_w-1:0] partial;
    logic [pp_w:0]   acc_sum;

    // Low byte of b gives this step's four digits
    radix4_partial_product pp_i (
        .a       (a_reg),
        .digits  (b_reg[step-1:0]),
        .product (partial)
    );

    // Upper half plus partial product
    cla_adder #(
        .width (pp_w)
    ) acc_add_i (
        .a   (partial),
        .b   ({{step{1'b0}}, acc[2*w-1:w]}),
        .sum (acc_sum)
    );

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            a_reg <= '0;
            b_reg <= '0;
            acc   <= '0;
        end else if (ctrl.load) begin
            a_reg <= req.a;
            b_reg <= req.b;
            acc   <= '0;
        end else if (ctrl.accumulate) begin
            b_reg <= b_reg >> step;
            // Sum lands on top, retired bits shift down
            acc   <= {acc_sum[pp_w-1:0], acc[w-1:step]};
        end
    end

    // Fixed-point slice of the finished product
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            y <= '0;
        end else if (ctrl.capture) begin
            y <= acc[`MUL_FRAC_BITS +: w];
        end
    end

endmodule

//--- logic/mul_pkg.sv
// Multiplier types
`include "mul_consts.svh"

package mul_pkg;

    // One operand or result
    typedef logic [`MUL_WIDTH-1:0] word_t;

    // Full accumulator image
    typedef logic [2*`MUL_WIDTH-1:0] product_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } mul_req_t;

    // Datapath strobes
    typedef struct packed {
        logic load;
        logic accumulate;
        logic capture;
    } mul_ctrl_t;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_calc   = 2'd1,
        st_finish = 2'd2
    } mul_state_t;

endpackage

//--- logic/radix4_partial_product.sv
// Radix-4 partial product
`timescale 1ns/100ps
`include "mul_consts.svh"

module radix4_partial_product import mul_pkg::*; (
    input  word_t                                       a,
    input  logic [`MUL_BITS_PER_STEP-1:0]               digits,
    output logic [`MUL_WIDTH+`MUL_BITS_PER_STEP-1:0]    product
);
    localparam int n_digits = `MUL_DIGITS_PER_STEP;
    localparam int pp_w     = `MUL_WIDTH + `MUL_BITS_PER_STEP;
    // 3a needs two extra bits
    localparam int mw       = `MUL_WIDTH + 2;

    logic [mw-1:0] a_x1;
    logic [mw-1:0] a_x2;
    logic [mw-1:0] a_x3;

    assign a_x1 = {2'b00, a};
    assign a_x2 = {1'b0, a, 1'b0};

    cla_adder #(
        .width (`MUL_WIDTH + 1)
    ) x3_add_i (
        .a   ({1'b0, a}),
        .b   ({a, 1'b0}),
        .sum (a_x3)
    );

    for (genvar i = 0; i < n_digits; i++) begin : row_g
        logic [mw-1:0] mult;
        logic [mw:0]   sum;

        always_comb begin
            case (digits[2*i +: 2])
                2'd0:    mult = '0;
                2'd1:    mult = a_x1;
                2'd2:    mult = a_x2;
                default: mult = a_x3;
            endcase
        end

        if (i == 0) begin : first_g
            assign sum = {1'b0, mult};
        end else begin : chain_g
            // Previous row moves down one digit
            cla_adder #(
                .width (mw)
            ) row_add_i (
                .a   (mult),
                .b   ({2'b00, row_g[i-1].sum[mw-1:2]}),
                .sum (sum)
            );
        end

        // Low digit of each row is final
        assign product[2*i +: 2] = sum[1:0];
    end

    assign product[pp_w-1:2*n_digits] = row_g[n_digits-1].sum[mw-1:2];

endmodule

//--- test/fixed_mul_tb.sv
// Fixed-point multiplier testbench
`timescale 1ns/100ps
`include "mul_consts.svh"

module fixed_mul_tb import mul_pkg::*; ();

    localparam int timeout_cycles = 20;
    localparam int latency        = 5;
    localparam int random_count   = 200;
    localparam int burst_count    = 4;

    logic     ctl_clk;
    logic     reset;
    logic     trigger;
    mul_req_t req;
    logic     ready;
    logic     done;
    word_t    y;

    fixed_mul_top dut_i (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .req     (req),
        .ready   (ready),
        .done    (done),
        .y       (y)
    );

    initial begin
        ctl_clk = 1'b0;
        forever #10 ctl_clk = ~ctl_clk;
    end

    task automatic end_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    // Full 64-bit product, shifted down by the fraction bits and truncated
    function automatic word_t model_y(input word_t a, input word_t b);
        logic [63:0] full;
        full = 64'(a) * 64'(b);
        return word_t'(full >> `MUL_FRAC_BITS);
    endfunction

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(negedge ctl_clk);
        while (!ready && cycles < timeout_cycles) begin
            @(negedge ctl_clk);
            cycles++;
        end
        assert (ready) else begin
            $display("Timed out waiting for ready to go high");
            end_with_failure();
        end
    endtask

    // Counts rising edges after the accepting edge until done is seen
    task automatic wait_done(output int cycles);
        cycles = 0;
        @(negedge ctl_clk);
        while (!done && cycles < timeout_cycles) begin
            @(negedge ctl_clk);
            cycles++;
        end
        assert (done) else begin
            $display("Timed out waiting for done");
            end_with_failure();
        end
    endtask

    // Second rising edge is the accepting edge
    task automatic issue_request(input word_t a, input word_t b);
        @(posedge ctl_clk);
        trigger <= 1'b1;
        req.a   <= a;
        req.b   <= b;
        @(posedge ctl_clk);
        trigger <= 1'b0;
    endtask

    task automatic run_product(input word_t a, input word_t b);
        int cycles;
        wait_ready();
        issue_request(a, b);
        wait_done(cycles);
        compare_word("done latency", word_t'(cycles), word_t'(latency));
        compare_word("y", y, model_y(a, b));
        compare_bit("ready", ready, 1'b1);
        @(negedge ctl_clk);
        compare_bit("done", done, 1'b0);
    endtask

    task automatic test_reset_state();
        @(negedge ctl_clk);
        compare_bit("ready", ready, 1'b1);
        compare_bit("done", done, 1'b0);
        compare_word("y", y, 32'h0000_0000);
    endtask

    task automatic test_directed_products();
        run_product(32'h0000_0000, 32'h1234_5678);
        run_product(32'hdead_beef, 32'h0000_0000);
        // 1.0 x 1.0
        run_product(32'h0000_0100, 32'h0000_0100);
        compare_word("y", y, 32'h0000_0100);
        // 1.5 x 2.25
        run_product(32'h0000_0180, 32'h0000_0240);
        compare_word("y", y, 32'h0000_0360);
        run_product(32'h0000_0080, 32'h0000_0080);
        run_product(32'h0000_0001, 32'h0000_00ff);
        run_product(32'h0003_243f, 32'h0000_02b8);
        run_product(32'hffff_ffff, 32'hffff_ffff);
        compare_word("y", y, 32'hfe00_0000);
        // Walking ones through every group and step
        for (int i = 0; i < `MUL_WIDTH; i++) begin
            run_product(32'h1 << i, 32'hffff_ffff);
            run_product(32'hffff_ffff, 32'h1 << i);
            run_product(32'h1 << i, 32'h1 << (`MUL_WIDTH - 1 - i));
        end
    endtask

    task automatic test_random_products();
        word_t a;
        word_t b;
        for (int n = 0; n < random_count; n++) begin
            a = $urandom;
            b = $urandom;
            run_product(a, b);
        end
    endtask

    task automatic test_back_to_back();
        word_t a_ops [burst_count];
        word_t b_ops [burst_count];
        int    cycles;
        for (int k = 0; k < burst_count; k++) begin
            a_ops[k] = $urandom;
            b_ops[k] = $urandom;
        end
        wait_ready();
        @(posedge ctl_clk);
        trigger <= 1'b1;
        req.a   <= a_ops[0];
        req.b   <= b_ops[0];
        for (int k = 0; k < burst_count; k++) begin
            // Accepting edge, next operands go out with it
            @(posedge ctl_clk);
            if (k < burst_count - 1) begin
                req.a <= a_ops[k+1];
                req.b <= b_ops[k+1];
            end else begin
                trigger <= 1'b0;
            end
            wait_done(cycles);
            compare_word("done latency", word_t'(cycles), word_t'(latency));
            compare_word("y", y, model_y(a_ops[k], b_ops[k]));
            compare_bit("ready", ready, 1'b1);
        end
        @(negedge ctl_clk);
        compare_bit("done", done, 1'b0);
    endtask

    task automatic test_busy_ignored();
        word_t a0;
        word_t b0;
        int    cycles;
        a0 = $urandom;
        b0 = $urandom;
        wait_ready();
        @(posedge ctl_clk);
        trigger <= 1'b1;
        req.a   <= a0;
        req.b   <= b0;
        // Accepting edge, junk operands from here on
        @(posedge ctl_clk);
        req.a <= $urandom;
        req.b <= $urandom;
        for (int i = 1; i <= latency; i++) begin
            @(negedge ctl_clk);
            compare_bit("ready", ready, 1'b0);
            compare_bit("done", done, 1'b0);
            @(posedge ctl_clk);
            if (i < latency) begin
                req.a <= $urandom;
                req.b <= $urandom;
            end else begin
                trigger <= 1'b0;
            end
        end
        wait_done(cycles);
        compare_word("y", y, model_y(a0, b0));
        // No new product and y holds
        for (int i = 0; i < 8; i++) begin
            @(negedge ctl_clk);
            compare_bit("done", done, 1'b0);
            compare_bit("ready", ready, 1'b1);
            compare_word("y", y, model_y(a0, b0));
        end
    endtask

    initial begin
        void'($urandom(32'h5685_2b2f));
        trigger = 1'b0;
        req     = '0;
        reset   = 1'b0;
        repeat (16) @(posedge ctl_clk);
        reset <= 1'b1;

        test_reset_state();
        test_directed_products();
        test_random_products();
        test_back_to_back();
        test_busy_ignored();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
